/* busActivityMonitor.f */
canFramePkg.sv
checkPkg.sv
frameCapture.sv
requestClassifier.sv
responseMatcher.sv
verdictCounter.sv
busActivityMonitor.sv
busActivityMonitor_props.sv
busActivityMonitor_tb.sv

/* Bender.yml */
package:
  name: busActivityMonitor

sources:
  # packages first, then the stages and the top level
  - files:
      - canFramePkg.sv
      - checkPkg.sv
      - frameCapture.sv
      - requestClassifier.sv
      - responseMatcher.sv
      - verdictCounter.sv
      - busActivityMonitor.sv

  - target: test
    files:
      - busActivityMonitor_props.sv
      - busActivityMonitor_tb.sv

/* busActivityMonitor_tb.sv */
// CAN transaction checker testbench
`timescale 1ns/1ps

module busActivityMonitor_tb
   import canFramePkg::*, checkPkg::*;
();

   localparam int ClkPeriod      = 20;
   localparam int FailCountWidth = 16;
   localparam int NumRows        = 19;

   typedef struct
   {
      testModeT   mode;
      busIdT      busId;
      canFrameT   upFrame;   // uplink during the request cycle
      canFrameT   downFrame;
      canFrameT   respFrame;
      checkClassT expClass;
      logic       expGood;
      logic       chained;   // sent back to back with the next row
   } rowT;

   logic                      clk;
   logic                      rst;
   busIdT                     busId;
   testModeT                  testMode;
   logic                      reqMsg;
   logic                      respMsg;
   canFrameT                  uplinkFrame;
   canFrameT                  downlinkFrame;
   logic                      checkValid;
   logic                      checkGood;
   checkClassT                checkClass;
   logic [FailCountWidth-1:0] failCount;
   logic                      anyFail;

   rowT rows [NumRows];
   int  rowCount = 0;
   int  badCount = 0;
   int  curRow   = -1;

   busActivityMonitor #(
      .FailCountWidth (FailCountWidth)
   ) u_dut (
      .clk           (clk),
      .rst           (rst),
      .busId         (busId),
      .testMode      (testMode),
      .reqMsg        (reqMsg),
      .respMsg       (respMsg),
      .uplinkFrame   (uplinkFrame),
      .downlinkFrame (downlinkFrame),
      .checkValid    (checkValid),
      .checkGood     (checkGood),
      .checkClass    (checkClass),
      .failCount     (failCount),
      .anyFail       (anyFail)
   );

   initial
   begin
      clk = 1'b0;
      forever #(ClkPeriod / 2) clk = ~clk;
   end

   // bounds the run by the table length
   initial
   begin
      #((NumRows * 10 + 50) * ClkPeriod);
      $display("Timeout: the run did not finish within %0d clock periods",
               NumRows * 10 + 50);
      $display("FAIL: see errors above");
      $fatal(1);
   end

   task automatic reportError(input string msg);
      $display("Error at time %0t: row %0d, %s", $time, curRow, msg);
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic compareBit(input string what, input logic got, input logic exp);
      if (got !== exp)
      begin
         reportError($sformatf("%s is %b, expected %b", what, got, exp));
      end
   endtask

   task automatic compareClass(input string what, input checkClassT got, input checkClassT exp);
      if (got !== exp)
      begin
         reportError($sformatf("%s is %s, expected %s", what, got.name(), exp.name()));
      end
   endtask

   task automatic compareCount(input string what, input logic [FailCountWidth-1:0] got,
                               input logic [FailCountWidth-1:0] exp);
      if (got !== exp)
      begin
         reportError($sformatf("%s is %0d, expected %0d", what, got, exp));
      end
   endtask

   function automatic canFrameT makeFrame(input logic [11:0] cobId, input logic [7:0] cmd,
                                          input logic [15:0] idx, input logic [7:0] sub,
                                          input logic [31:0] data);
      return {cobId, cmd, idx, sub, data};
   endfunction

   function automatic canFrameT sdoRead(input logic [15:0] idx, input logic [7:0] sub);
      return makeFrame(12'h601, 8'h40, idx, sub, 32'h0);
   endfunction

   function automatic canFrameT sdoReply(input logic [15:0] idx, input logic [7:0] sub,
                                         input logic [31:0] data);
      return makeFrame(12'h581, 8'h43, idx, sub, data);
   endfunction

   function automatic canFrameT randFrame();
      logic [95:0] r;
      r = {$urandom, $urandom, $urandom};
      return r[75:0];
   endfunction

   task automatic addRow(input testModeT mode, input busIdT id, input canFrameT up,
                         input canFrameT down, input canFrameT resp, input checkClassT cls,
                         input logic good, input logic chained);
      rows[rowCount] = '{mode, id, up, down, resp, cls, good, chained};
      rowCount++;
   endtask

   task automatic buildTable();
      canFrameT ng;
      canFrameT lbRx;
      canFrameT lbRxOk;
      canFrameT lbRxBad;
      canFrameT lbTx;
      canFrameT lbTxOk;
      canFrameT lbTxBad;
      canFrameT trimOk;
      canFrameT trimBad;
      ng = makeFrame(12'h701, 8'h00, 16'h0, 8'h00, 32'h0);
      lbRx = randFrame();
      lbRx.cobId = 12'h181; // PDO COB-ID is never decoded as a special class
      lbRxOk = lbRx;
      lbRxOk.data[7:0] = 8'($urandom);
      lbRxBad = lbRxOk;
      lbRxBad.objIndex = lbRx.objIndex ^ 16'h0001;
      lbTx = randFrame();
      lbTx.cobId = 12'h281;
      lbTxOk = lbTx;
      lbTxOk.data[7:0] = 8'($urandom);
      lbTxBad = lbTxOk;
      lbTxBad.data = lbTxOk.data ^ 32'h100; // just above the free byte
      trimOk = OscTrimPattern;
      trimOk.subIndex = 8'h23;
      trimBad = trimOk;
      trimBad.subIndex = 8'h24;

      addRow(modeDefault, 8'h12, ng, randFrame(),
             makeFrame(12'h701, 8'h05, 16'h0, 8'h00, 32'h0), classNodeGuard, 1'b1, 1'b0);
      addRow(modeDefault, 8'h12, ng, randFrame(),
             makeFrame(12'h701, 8'h05, 16'h0, 8'h00, 32'h1), classNodeGuard, 1'b0, 1'b0);
      addRow(modeDefault, 8'h12, sdoRead(16'h1000, 8'h00), randFrame(),
             sdoReply(16'h1000, 8'h00, 32'h191), classSdoTable, 1'b1, 1'b0);
      addRow(modeDefault, 8'h12, sdoRead(16'h1001, 8'h00), randFrame(),
             sdoReply(16'h1001, 8'h00, 32'h0), classSdoTable, 1'b1, 1'b0);
      addRow(modeDefault, 8'h12, sdoRead(16'h1005, 8'h00), randFrame(),
             sdoReply(16'h1005, 8'h00, 32'h80), classSdoTable, 1'b1, 1'b0);
      addRow(modeDefault, 8'h12, sdoRead(16'h1014, 8'h00), randFrame(),
             sdoReply(16'h1014, 8'h00, 32'h81), classSdoTable, 1'b1, 1'b0);
      addRow(modeDefault, 8'h12, sdoRead(16'h1014, 8'h00), randFrame(),
             sdoReply(16'h1014, 8'h00, 32'h80), classSdoTable, 1'b0, 1'b0);
      addRow(modeDefault, 8'h12, sdoRead(16'h2002, 8'h12), randFrame(),
             sdoReply(16'h2002, 8'h12, 32'h1), classSignIn, 1'b1, 1'b0);
      addRow(modeDefault, 8'h12, sdoRead(16'h2003, 8'h12), randFrame(),
             sdoReply(16'h2003, 8'h12, 32'h1), classSignIn, 1'b1, 1'b0);
      addRow(modeDefault, 8'h12, sdoRead(16'h2004, 8'h12), randFrame(),
             sdoReply(16'h2004, 8'h12, 32'h0), classSignIn, 1'b1, 1'b0);
      // subindex is not this bus
      addRow(modeDefault, 8'h12, sdoRead(16'h2002, 8'h13), randFrame(),
             sdoReply(16'h2002, 8'h13, 32'h1), classLoopback, 1'b0, 1'b0);
      addRow(modeOscTrim, 8'h23, randFrame(), randFrame(), trimOk, classOscTrim, 1'b1, 1'b0);
      addRow(modeOscTrim, 8'h23, randFrame(), randFrame(), trimBad, classOscTrim, 1'b0, 1'b0);
      addRow(modeRx, 8'h12, lbRx, randFrame(), lbRxOk, classLoopback, 1'b1, 1'b0);
      addRow(modeRx, 8'h12, lbRx, randFrame(), lbRxBad, classLoopback, 1'b0, 1'b0);
      addRow(modeTx, 8'h12, randFrame(), lbTx, lbTxOk, classLoopback, 1'b1, 1'b0);
      addRow(modeTx, 8'h12, randFrame(), lbTx, lbTxBad, classLoopback, 1'b0, 1'b0);
      // back-to-back responses with the second request in the first response cycle
      addRow(modeTx, 8'h12, randFrame(), ng,
             makeFrame(12'h701, 8'h05, 16'h0, 8'h00, 32'h0), classNodeGuard, 1'b1, 1'b1);
      addRow(modeTx, 8'h12, randFrame(), sdoRead(16'h1001, 8'h00),
             sdoReply(16'h1001, 8'h00, 32'h5), classSdoTable, 1'b0, 1'b0);
   endtask

   task automatic checkVerdict(input rowT r);
      if (!r.expGood)
      begin
         badCount++;
      end
      compareBit("checkValid", checkValid, 1'b1);
      compareClass("checkClass", checkClass, r.expClass);
      compareBit("checkGood", checkGood, r.expGood);
      compareCount("failCount", failCount, FailCountWidth'(badCount));
      compareBit("anyFail", anyFail, badCount != 0);
   endtask

   task automatic checkIdle(input int cycles);
      repeat (cycles)
      begin
         @(negedge clk);
         compareBit("checkValid", checkValid, 1'b0);
         compareBit("checkGood", checkGood, 1'b0);
         compareCount("failCount", failCount, '0);
         compareBit("anyFail", anyFail, 1'b0);
      end
   endtask

   task automatic applyRow(input rowT r);
      @(posedge clk);
      testMode      <= r.mode;
      busId         <= r.busId;
      uplinkFrame   <= r.upFrame;
      downlinkFrame <= r.downFrame;
      reqMsg        <= 1'b1;
      @(posedge clk);
      reqMsg      <= 1'b0;
      respMsg     <= 1'b1;
      uplinkFrame <= r.respFrame;
      @(posedge clk);
      respMsg <= 1'b0;
      @(negedge clk);
      compareBit("checkValid before its cycle", checkValid, 1'b0);
      @(negedge clk);
      checkVerdict(r);
      @(negedge clk);
      compareBit("checkValid after its cycle", checkValid, 1'b0);
   endtask

   task automatic applyPair(input rowT a, input rowT b);
      @(posedge clk);
      testMode      <= a.mode;
      busId         <= a.busId;
      uplinkFrame   <= a.upFrame;
      downlinkFrame <= a.downFrame;
      reqMsg        <= 1'b1;
      @(posedge clk);
      downlinkFrame <= b.downFrame; // reqMsg stays high
      uplinkFrame   <= a.respFrame;
      respMsg       <= 1'b1;
      @(posedge clk);
      reqMsg      <= 1'b0;
      uplinkFrame <= b.respFrame;
      @(posedge clk);
      respMsg <= 1'b0;
      @(negedge clk);
      checkVerdict(a);
      curRow++;
      @(negedge clk);
      checkVerdict(b);
      @(negedge clk);
      compareBit("checkValid after the pair", checkValid, 1'b0);
   endtask

   initial
   begin
      void'($urandom(32'hbe3c));
      rst           <= 1'b0;
      testMode      <= modeDefault;
      busId         <= '0;
      reqMsg        <= 1'b0;
      respMsg       <= 1'b0;
      uplinkFrame   <= '0;
      downlinkFrame <= '0;
      buildTable();
      repeat (3) @(posedge clk);
      rst <= 1'b1;
      checkIdle(5); // nothing without respMsg
      curRow = 0;
      while (curRow < rowCount)
      begin
         if (rows[curRow].chained)
         begin
            applyPair(rows[curRow], rows[curRow + 1]);
         end
         else
         begin
            applyRow(rows[curRow]);
         end
         curRow++;
      end
      $display("PASS: all tests");
      $finish;
   end

endmodule

/* busActivityMonitor_props.sv */
// Verdict timing and counter properties
`timescale 1ns/1ps

module busActivityMonitor_props #(
   parameter int FailCountWidth = 16
)
(
   input logic                      clk,
   input logic                      rst,
   input logic                      pairValid,
   input logic                      checkValid,
   input logic [FailCountWidth-1:0] failCount,
   input logic                      anyFail
);

   // verdict exactly one cycle after the pair
   verdictAfterPair: assert property (@(posedge clk) disable iff (!rst)
      pairValid |=> checkValid)
      else $error("checkValid missing one cycle after pairValid");

   verdictOnlyAfterPair: assert property (@(posedge clk) disable iff (!rst)
      checkValid |-> $past(pairValid))
      else $error("checkValid without pairValid in the cycle before");

   countNeverDrops: assert property (@(posedge clk) disable iff (!rst)
      $past(rst) |-> failCount >= $past(failCount))
      else $error("failCount decreased");

   flagWithCount: assert property (@(posedge clk) disable iff (!rst)
      failCount != '0 |-> anyFail)
      else $error("anyFail low while failCount is non-zero");

endmodule

bind verdictCounter busActivityMonitor_props #(
   .FailCountWidth (FailCountWidth)
) u_props (
   .clk        (clk),
   .rst        (rst),
   .pairValid  (pairValid),
   .checkValid (checkValid),
   .failCount  (failCount),
   .anyFail    (anyFail)
);

/* busActivityMonitor.sv */
// CAN bus transaction checker
`timescale 1ns/1ps

module busActivityMonitor
   import canFramePkg::*, checkPkg::*;
#(
   parameter int FailCountWidth = 16
)
(
   input  logic                      clk,
   input  logic                      rst,
   input  busIdT                     busId,
   input  testModeT                  testMode,
   input  logic                      reqMsg,
   input  logic                      respMsg,
   input  canFrameT                  uplinkFrame,
   input  canFrameT                  downlinkFrame,
   output logic                      checkValid,
   output logic                      checkGood,
   output checkClassT                checkClass,
   output logic [FailCountWidth-1:0] failCount,
   output logic                      anyFail
);

   logic                     pairValid;
   canFrameT                 reqFrame;
   canFrameT                 respFrame;
   checkClassT               reqClass;
   logic [TableIdxWidth-1:0] tableIdx;
   logic                     respGood;

   frameCapture u_frameCapture (
      .clk           (clk),
      .rst           (rst),
      .testMode      (testMode),
      .reqMsg        (reqMsg),
      .respMsg       (respMsg),
      .uplinkFrame   (uplinkFrame),
      .downlinkFrame (downlinkFrame),
      .pairValid     (pairValid),
      .reqFrame      (reqFrame),
      .respFrame     (respFrame)
   );

   requestClassifier u_requestClassifier (
      .reqFrame (reqFrame),
      .busId    (busId),
      .reqClass (reqClass),
      .tableIdx (tableIdx)
   );

   responseMatcher u_responseMatcher (
      .reqClass  (reqClass),
      .tableIdx  (tableIdx),
      .reqFrame  (reqFrame),
      .respFrame (respFrame),
      .busId     (busId),
      .respGood  (respGood)
   );

   verdictCounter #(
      .FailCountWidth (FailCountWidth)
   ) u_verdictCounter (
      .clk        (clk),
      .rst        (rst),
      .pairValid  (pairValid),
      .reqClass   (reqClass),
      .respGood   (respGood),
      .checkValid (checkValid),
      .checkGood  (checkGood),
      .checkClass (checkClass),
      .failCount  (failCount),
      .anyFail    (anyFail)
   );

endmodule

/* verdictCounter.sv */
// Verdict register and failure counter
`timescale 1ns/1ps

module verdictCounter
   import checkPkg::*;
#(
   parameter int FailCountWidth = 16
)
(
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      pairValid,
   input  checkClassT                reqClass,
   input  logic                      respGood,
   output logic                      checkValid,
   output logic                      checkGood,
   output checkClassT                checkClass,
   output logic [FailCountWidth-1:0] failCount,
   output logic                      anyFail
);

   always_ff @(posedge clk)
   begin
      if (pairValid)
      begin
         checkClass <= reqClass;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst)
      begin
         checkValid <= 1'b0;
         checkGood  <= 1'b0;
         failCount  <= '0;
         anyFail    <= 1'b0;
      end
      else
      begin
         checkValid <= pairValid;
         if (pairValid)
         begin
            checkGood <= respGood;
            if (!respGood)
            begin
               anyFail <= 1'b1; // sticky until reset
               if (failCount != '1)
               begin
                  failCount <= failCount + 1'b1; // saturates
               end
            end
         end
      end
   end

endmodule

/* responseMatcher.sv */
// Response rule check per class
`timescale 1ns/1ps

module responseMatcher
   import canFramePkg::*, checkPkg::*;
(
   input  checkClassT               reqClass,
   input  logic [TableIdxWidth-1:0] tableIdx,
   input  canFrameT                 reqFrame,
   input  canFrameT                 respFrame,
   input  busIdT                    busId,
   output logic                     respGood
);

   canFrameT    nodeGuardExp;
   canFrameT    sdoExp;
   canFrameT    trimExp;
   logic [31:0] sdoData;

   // node guard reply carries only the state nibble
   always_comb
   begin
      nodeGuardExp        = '0;
      nodeGuardExp.cobId  = NodeGuardCobId;
      nodeGuardExp.sdoCmd = {4'h0, NodeGuardState};
   end

   // sign-in objects A and B read 1, C reads 0
   always_comb
   begin
      if (reqClass == classSignIn)
      begin
         sdoData = (reqFrame.objIndex == SignInIndexC) ? 32'h0 : 32'h1;
      end
      else
      begin
         sdoData = sdoTable[tableIdx].data;
      end
   end

   always_comb
   begin
      sdoExp        = reqFrame; // keeps index and subindex
      sdoExp.cobId  = SdoResponseCobId;
      sdoExp.sdoCmd = SdoReadRespCmd;
      sdoExp.data   = sdoData;
   end

   always_comb
   begin
      trimExp          = OscTrimPattern;
      trimExp.subIndex = busId;
   end

   always_comb
   begin
      case (reqClass)
         classNodeGuard:
         begin
            respGood = (respFrame == nodeGuardExp);
         end
         classSdoTable, classSignIn:
         begin
            respGood = (respFrame == sdoExp);
         end
         classOscTrim:
         begin
            respGood = (respFrame == trimExp);
         end
         default:
         begin
            respGood = (respFrame[75:8] == reqFrame[75:8]); // low data byte free
         end
      endcase
   end

endmodule

/* requestClassifier.sv */
// Request class decoder
`timescale 1ns/1ps

module requestClassifier
   import canFramePkg::*, checkPkg::*;
(
   input  canFrameT                 reqFrame,
   input  busIdT                    busId,
   output checkClassT               reqClass,
   output logic [TableIdxWidth-1:0] tableIdx
);

   logic isSdoRead;
   logic isSignInObj;
   logic isSignIn;
   logic tableHit;

   assign isSdoRead = (reqFrame.cobId == SdoRequestCobId) &&
                      (reqFrame.sdoCmd == SdoReadCmd);

   assign isSignInObj = (reqFrame.objIndex == SignInIndexA) ||
                        (reqFrame.objIndex == SignInIndexB) ||
                        (reqFrame.objIndex == SignInIndexC);

   // sign-in reads address the bus ID in the subindex
   assign isSignIn = isSdoRead && isSignInObj &&
                     (reqFrame.subIndex == busId) && (reqFrame.data == '0);

   // first table entry with matching index/subindex
   always_comb
   begin
      tableHit = 1'b0;
      tableIdx = '0;
      for (int i = 0; i < SdoTableSize; i++)
      begin
         if (!tableHit && isSdoRead &&
             (reqFrame.objIndex == sdoTable[i].objIndex) &&
             (reqFrame.subIndex == sdoTable[i].subIndex))
         begin
            tableHit = 1'b1;
            tableIdx = TableIdxWidth'(i);
         end
      end
   end

   always_comb
   begin
      if (reqFrame == OscTrimPattern)
      begin
         reqClass = classOscTrim;
      end
      else if (reqFrame.cobId == NodeGuardCobId)
      begin
         reqClass = classNodeGuard;
      end
      else if (isSignIn)
      begin
         reqClass = classSignIn;
      end
      else if (tableHit)
      begin
         reqClass = classSdoTable;
      end
      else
      begin
         reqClass = classLoopback; // echo of an RX/TX frame
      end
   end

endmodule

/* frameCapture.sv */
// Request capture and pairing
`timescale 1ns/1ps

module frameCapture
   import canFramePkg::*, checkPkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  testModeT testMode,
   input  logic     reqMsg,
   input  logic     respMsg,
   input  canFrameT uplinkFrame,
   input  canFrameT downlinkFrame,
   output logic     pairValid,
   output canFrameT reqFrame,
   output canFrameT respFrame
);

   canFrameT reqSource;
   canFrameT curReq; // latest request, waiting for its response

   always_comb
   begin
      case (testMode)
         modeTx:      reqSource = downlinkFrame;
         modeOscTrim: reqSource = OscTrimPattern;
         default:     reqSource = uplinkFrame; // default and RX
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reqMsg)
      begin
         curReq <= reqSource;
      end
   end

   // old curReq is taken, so a same-cycle request waits for the next response
   always_ff @(posedge clk)
   begin
      if (respMsg)
      begin
         reqFrame  <= curReq;
         respFrame <= uplinkFrame;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst)
      begin
         pairValid <= 1'b0;
      end
      else
      begin
         pairValid <= respMsg; // one cycle after the response strobe
      end
   end

endmodule

/* checkPkg.sv */
// Checker modes and classes
package checkPkg;

   // source of the stored request copy
   typedef enum logic [1:0]
   {
      modeDefault,
      modeRx,
      modeTx,
      modeOscTrim
   } testModeT;

   // rule used to judge a request/response pair
   typedef enum logic [2:0]
   {
      classNodeGuard,
      classSdoTable,
      classSignIn,
      classOscTrim,
      classLoopback
   } checkClassT;

   // request seen during oscillator trimming
   localparam logic [75:0] OscTrimPattern = 76'h555_aaaa_aaaa_aaaa_aaaa;

endpackage

/* canFramePkg.sv */
// CAN frame layout and SDO constants
package canFramePkg;

   // 76-bit frame as carried on the uplink and downlink streams
   typedef struct packed
   {
      logic [11:0] cobId;
      logic [7:0]  sdoCmd;
      logic [15:0] objIndex;
      logic [7:0]  subIndex;
      logic [31:0] data;
   } canFrameT;

   typedef logic [7:0] busIdT;

   localparam logic [11:0] NodeGuardCobId   = 12'h701;
   localparam logic [11:0] SdoRequestCobId  = 12'h601;
   localparam logic [11:0] SdoResponseCobId = 12'h581;

   localparam logic [7:0] SdoReadCmd     = 8'h40;
   localparam logic [7:0] SdoReadRespCmd = 8'h43; // expedited, 4 data bytes

   localparam logic [3:0] NodeGuardState = 4'h5; // operational

   // sign-in objects, subindex carries the bus ID
   localparam logic [15:0] SignInIndexA = 16'h2002;
   localparam logic [15:0] SignInIndexB = 16'h2003;
   localparam logic [15:0] SignInIndexC = 16'h2004;

   localparam int SdoTableSize  = 4;
   localparam int TableIdxWidth = $clog2(SdoTableSize);

   typedef struct packed
   {
      logic [15:0] objIndex;
      logic [7:0]  subIndex;
      logic [31:0] data;
   } sdoEntryT;

   // expected read values of the node's identity objects
   localparam sdoEntryT sdoTable [SdoTableSize] = '{
      '{objIndex: 16'h1000, subIndex: 8'h00, data: 32'h0000_0191}, // device type
      '{objIndex: 16'h1001, subIndex: 8'h00, data: 32'h0000_0000}, // error register
      '{objIndex: 16'h1005, subIndex: 8'h00, data: 32'h0000_0080}, // SYNC COB-ID
      '{objIndex: 16'h1014, subIndex: 8'h00, data: 32'h0000_0081}  // EMCY COB-ID
   };

endpackage
